// File: all.f
+incdir+sim
source/copad_geom_pkg.sv
source/copad_match_pkg.sv
source/copad_window.sv
source/copad_pair_match.sv
source/copad_result.sv
source/copad_top.sv
sim/copad_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the co-pad finder testbench with Verilator.
# Pass or fail is taken from the simulation log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log
SIM_BIN=copad_sim

rm -rf "$BUILD_DIR"

verilator --binary --timing --assert \
    -f all.f \
    --top-module copad_tb \
    -Mdir "$BUILD_DIR" \
    -o "$SIM_BIN" > "$BUILD_LOG" 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed with status $build_status"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if grep -q "Done: errors found" "$SIM_LOG"; then
    echo "FAIL: testbench reported errors"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "FAIL: simulation exited with status $sim_status"
    exit 1
fi

echo "PASS"
exit 0

// File: sim/copad_tb_cases.svh
//--------------------
// directed crossings for the co-pad finder testbench
// row layout and the table of stimulus with expected results
//--------------------

`ifndef COPAD_TB_CASES_SVH
`define COPAD_TB_CASES_SVH

// per-cluster fields are packed with cluster 0 in the low bits,
// rolls and counts in octal so that each digit is one cluster
typedef struct packed {
    logic [7:0]  a_vpf;
    logic [23:0] a_roll;
    logic [63:0] a_pad;
    logic [23:0] a_cnt;
    logic [7:0]  b_vpf;
    logic [23:0] b_roll;
    logic [63:0] b_pad;
    logic [23:0] b_cnt;
    logic        npad;       // match_neighbor_pad
    logic [3:0]  delta;      // match_delta_pad
    logic        nroll;      // match_neighbor_roll
    logic [1:0]  idle;       // idle cycles after the strobe
    logic [7:0]  exp_match;
    logic [7:0]  exp_upper;
    logic [7:0]  exp_lower;
} crossing_row_t;

localparam int N_CASES = 9;

localparam crossing_row_t CASES [N_CASES] = '{
    // exact span, B start or end inside, one pad outside on each side
    '{8'h0f, 24'o00005432, 64'h00000000_7864320a, 24'o00000102,
      8'h0f, 24'o00005432, 64'h00000000_75662f0c, 24'o00002030,
      1'b0, 4'd0, 1'b0, 2'd2, 8'h03, 8'h00, 8'h00},
    // delta 3, clamped at pad 0 and pad 191, one pad beyond the widening
    '{8'h0f, 24'o00003361, 64'h00000000_503cbe01, 24'o00001000,
      8'h0f, 24'o00003361, 64'h00000000_4740bf00, 24'o00006000,
      1'b1, 4'd3, 1'b0, 2'd1, 8'h0b, 8'h00, 8'h00},
    // neighbor rolls, option off; roll 0 and 7 do not wrap
    '{8'h0f, 24'o00007033, 64'h00000000_503c2814, 24'o00000000,
      8'h0f, 24'o00000742, 64'h00000000_503c2814, 24'o00000000,
      1'b0, 4'd0, 1'b0, 2'd0, 8'h00, 8'h01, 8'h02},
    // same clusters, neighbor rolls now count
    '{8'h0f, 24'o00007033, 64'h00000000_503c2814, 24'o00000000,
      8'h0f, 24'o00000742, 64'h00000000_503c2814, 24'o00000000,
      1'b0, 4'd0, 1'b1, 2'd1, 8'h03, 8'h01, 8'h02},
    // edge rolls: roll 0 only looks down, roll 7 only looks up
    '{8'h0f, 24'o00007070, 64'h00000000_96641e1e, 24'o00000000,
      8'h0f, 24'o00000761, 64'h00000000_96641e1e, 24'o00000000,
      1'b0, 4'd0, 1'b1, 2'd1, 8'h03, 8'h02, 8'h01},
    // invalid A or B never matches
    '{8'h05, 24'o00000542, 64'h00000000_005a460a, 24'o00000100,
      8'h06, 24'o00000542, 64'h00000000_005b460a, 24'o00000000,
      1'b1, 4'd2, 1'b1, 2'd0, 8'h04, 8'h00, 8'h00},
    // all eight clusters, every other one just misses
    '{8'hff, 24'o76543210, 64'h917d6955_412d1905, 24'o11111111,
      8'hff, 24'o76543210, 64'h957e6d56_452e1d06, 24'o00000000,
      1'b0, 4'd0, 1'b0, 2'd0, 8'h55, 8'h00, 8'h00},
    // empty crossing clears the held result
    '{8'h00, 24'o00000000, 64'h00000000_00000000, 24'o00000000,
      8'h00, 24'o00000000, 64'h00000000_00000000, 24'o00000000,
      1'b0, 4'd0, 1'b0, 2'd0, 8'h00, 8'h00, 8'h00},
    // B wider than the window on both sides is no overlap
    '{8'h03, 24'o00000011, 64'h00000000_00006432, 24'o00000070,
      8'h03, 24'o00000011, 64'h00000000_00006730, 24'o00000024,
      1'b0, 4'd0, 1'b1, 2'd3, 8'h02, 8'h00, 8'h00}
};

`endif

// File: sim/copad_tb.sv
//--------------------
// co-pad finder testbench
// clock and reset, directed table, random crossings,
// reference model, output checks and watchdog
//--------------------

`timescale 1ns/100ps

module copad_tb;

    localparam int N_RANDOM = 200;
    localparam int SEED     = 32'h32ef391e;

    logic                                                   clock;
    logic                                                   rst_n;
    logic                                                   bx_strobe;
    copad_match_pkg::cluster_vec_t                          a_vpf;
    copad_geom_pkg::roll_t [copad_geom_pkg::N_CLUSTERS-1:0] a_roll;
    copad_geom_pkg::pad_t  [copad_geom_pkg::N_CLUSTERS-1:0] a_pad;
    copad_geom_pkg::cnt_t  [copad_geom_pkg::N_CLUSTERS-1:0] a_cnt;
    copad_match_pkg::cluster_vec_t                          b_vpf;
    copad_geom_pkg::roll_t [copad_geom_pkg::N_CLUSTERS-1:0] b_roll;
    copad_geom_pkg::pad_t  [copad_geom_pkg::N_CLUSTERS-1:0] b_pad;
    copad_geom_pkg::cnt_t  [copad_geom_pkg::N_CLUSTERS-1:0] b_cnt;
    logic                                                   match_neighbor_pad;
    copad_match_pkg::delta_t                                match_delta_pad;
    logic                                                   match_neighbor_roll;
    logic                                                   result_strobe;
    copad_match_pkg::cluster_vec_t                          match;
    copad_match_pkg::cluster_vec_t                          match_upper;
    copad_match_pkg::cluster_vec_t                          match_lower;
    logic                                                   any_match;

    `include "copad_tb_cases.svh"

    // worst case is a crossing plus three idle cycles
    localparam int TIMEOUT_CYCLES = 4 * (N_CASES + N_RANDOM) + 50;

    int                            exp_due [$];   // cycle of the expected result strobe
    copad_match_pkg::cluster_vec_t exp_match [$];
    copad_match_pkg::cluster_vec_t exp_upper [$];
    copad_match_pkg::cluster_vec_t exp_lower [$];
    copad_match_pkg::cluster_vec_t last_match = '0;  // outputs hold between results
    copad_match_pkg::cluster_vec_t last_upper = '0;
    copad_match_pkg::cluster_vec_t last_lower = '0;
    int                            cycle      = 0;

    copad_top dut0 (
        .clock, .rst_n, .bx_strobe,
        .a_vpf, .a_roll, .a_pad, .a_cnt,
        .b_vpf, .b_roll, .b_pad, .b_cnt,
        .match_neighbor_pad, .match_delta_pad, .match_neighbor_roll,
        .result_strobe, .match, .match_upper, .match_lower, .any_match
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            fail_run("timeout, the run did not finish within the cycle limit");
        end
    end

    //--------------------
    // reporting
    //--------------------

    task automatic stop_on_error();
        $display("Done: errors found");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic fail_run(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        stop_on_error();
    endtask

    task automatic compare(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    //--------------------
    // reference model
    //--------------------

    // works on the inputs as they are driven for the crossing
    function automatic void model_crossing(output copad_match_pkg::cluster_vec_t m,
                                           output copad_match_pkg::cluster_vec_t u,
                                           output copad_match_pkg::cluster_vec_t l);
        copad_match_pkg::cluster_vec_t same;
        int dlt;
        int lo;
        int hi;
        int bs;
        int be;
        same = '0;
        u    = '0;
        l    = '0;
        dlt  = match_neighbor_pad ? int'(match_delta_pad) : 0;
        for (int i = 0; i < copad_geom_pkg::N_CLUSTERS; i++) begin
            lo = int'(a_pad[i]) - dlt;
            hi = int'(a_pad[i]) + int'(a_cnt[i]) + dlt;
            if (lo < 0) lo = 0;
            if (hi > copad_geom_pkg::MAX_PAD) hi = copad_geom_pkg::MAX_PAD;
            for (int j = 0; j < copad_geom_pkg::N_CLUSTERS; j++) begin
                bs = int'(b_pad[j]);
                be = bs + int'(b_cnt[j]);
                if (a_vpf[i] && b_vpf[j]
                    && ((bs >= lo && bs <= hi) || (be >= lo && be <= hi))) begin
                    if (b_roll[j] == a_roll[i]) same[i] = 1'b1;
                    // roll 0 minus one and roll 7 plus one fall off the chamber
                    if (int'(b_roll[j]) == int'(a_roll[i]) - 1) u[i] = 1'b1;
                    if (int'(b_roll[j]) == int'(a_roll[i]) + 1) l[i] = 1'b1;
                end
            end
        end
        m = match_neighbor_roll ? (same | u | l) : same;
    endfunction

    //--------------------
    // stimulus and checks
    //--------------------

    task automatic push_expected(input copad_match_pkg::cluster_vec_t m,
                                 input copad_match_pkg::cluster_vec_t u,
                                 input copad_match_pkg::cluster_vec_t l);
        exp_due.push_back(cycle + copad_match_pkg::PIPE_LATENCY);
        exp_match.push_back(m);
        exp_upper.push_back(u);
        exp_lower.push_back(l);
    endtask

    // outputs are sampled on the falling edge, half a cycle after they change
    task automatic check_outputs();
        if (exp_due.size() != 0 && exp_due[0] == cycle) begin
            if (result_strobe !== 1'b1) begin
                fail_run($sformatf("result_strobe missing for the crossing due in cycle %0d",
                                   cycle));
            end else begin
                void'(exp_due.pop_front());
                last_match = exp_match.pop_front();
                last_upper = exp_upper.pop_front();
                last_lower = exp_lower.pop_front();
            end
        end else if (result_strobe !== 1'b0) begin
            fail_run("result_strobe is high with no crossing due");
        end
        compare(match, last_match, "match");
        compare(match_upper, last_upper, "match_upper");
        compare(match_lower, last_lower, "match_lower");
        compare({7'd0, any_match}, {7'd0, |last_match}, "any_match");
    endtask

    task automatic tick();
        @(negedge clock);
        check_outputs();
    endtask

    task automatic clear_inputs();
        bx_strobe           = 1'b0;
        a_vpf               = '0;
        a_roll              = '0;
        a_pad               = '0;
        a_cnt               = '0;
        b_vpf               = '0;
        b_roll              = '0;
        b_pad               = '0;
        b_cnt               = '0;
        match_neighbor_pad  = 1'b0;
        match_delta_pad     = '0;
        match_neighbor_roll = 1'b0;
    endtask

    task automatic drive_row(input crossing_row_t row);
        a_vpf               = row.a_vpf;
        a_roll              = row.a_roll;
        a_pad               = row.a_pad;
        a_cnt               = row.a_cnt;
        b_vpf               = row.b_vpf;
        b_roll              = row.b_roll;
        b_pad               = row.b_pad;
        b_cnt               = row.b_cnt;
        match_neighbor_pad  = row.npad;
        match_delta_pad     = row.delta;
        match_neighbor_roll = row.nroll;
        bx_strobe           = 1'b1;
        push_expected(row.exp_match, row.exp_upper, row.exp_lower);
    endtask

    // even crossings crowd the pads into a narrow band so that overlaps are common
    task automatic drive_random(input int n);
        copad_match_pkg::cluster_vec_t m;
        copad_match_pkg::cluster_vec_t u;
        copad_match_pkg::cluster_vec_t l;
        int base;
        base  = $urandom_range(copad_geom_pkg::MAX_PAD - 15, 0);
        a_vpf = 8'($urandom);
        b_vpf = 8'($urandom);
        for (int k = 0; k < copad_geom_pkg::N_CLUSTERS; k++) begin
            a_roll[k] = 3'($urandom);
            b_roll[k] = 3'($urandom);
            a_cnt[k]  = 3'($urandom);
            b_cnt[k]  = 3'($urandom);
            if (n % 2 == 0) begin
                a_pad[k] = 8'(base + $urandom_range(15, 0));
                b_pad[k] = 8'(base + $urandom_range(15, 0));
            end else begin
                a_pad[k] = 8'($urandom_range(copad_geom_pkg::MAX_PAD, 0));
                b_pad[k] = 8'($urandom_range(copad_geom_pkg::MAX_PAD, 0));
            end
        end
        match_neighbor_pad  = 1'($urandom);
        match_delta_pad     = 4'($urandom);
        match_neighbor_roll = 1'($urandom);
        bx_strobe           = 1'b1;
        model_crossing(m, u, l);
        push_expected(m, u, l);
    endtask

    initial begin : main
        int idle;
        void'($urandom(SEED));
        clear_inputs();
        rst_n = 1'b0;
        repeat (3) @(negedge clock);
        rst_n = 1'b1;

        repeat (3) tick();   // no strobe yet so everything stays at zero

        for (int r = 0; r < N_CASES; r++) begin
            tick();
            drive_row(CASES[r]);
            repeat (CASES[r].idle) begin
                tick();
                bx_strobe = 1'b0;
            end
        end

        for (int n = 0; n < N_RANDOM; n++) begin
            tick();
            drive_random(n);
            idle = $urandom_range(2, 0);
            repeat (idle) begin
                tick();
                bx_strobe = 1'b0;
            end
        end

        tick();
        bx_strobe = 1'b0;
        while (exp_due.size() != 0) begin
            tick();
        end
        repeat (2) tick();   // no stray strobe after the last result

        $display("Done: no errors");
        $finish;
    end

endmodule

// File: source/copad_top.sv
//--------------------
// copad_top
// co-pad finder top level
// window -> pair match -> result
//--------------------

`timescale 1ns/100ps

module copad_top (
    input  logic                                                  clock,
    input  logic                                                  rst_n,
    input  logic                                                  bx_strobe,
    input  copad_match_pkg::cluster_vec_t                         a_vpf,
    input  copad_geom_pkg::roll_t [copad_geom_pkg::N_CLUSTERS-1:0] a_roll,
    input  copad_geom_pkg::pad_t  [copad_geom_pkg::N_CLUSTERS-1:0] a_pad,
    input  copad_geom_pkg::cnt_t  [copad_geom_pkg::N_CLUSTERS-1:0] a_cnt,
    input  copad_match_pkg::cluster_vec_t                         b_vpf,
    input  copad_geom_pkg::roll_t [copad_geom_pkg::N_CLUSTERS-1:0] b_roll,
    input  copad_geom_pkg::pad_t  [copad_geom_pkg::N_CLUSTERS-1:0] b_pad,
    input  copad_geom_pkg::cnt_t  [copad_geom_pkg::N_CLUSTERS-1:0] b_cnt,
    input  logic                                                  match_neighbor_pad,
    input  copad_match_pkg::delta_t                               match_delta_pad,
    input  logic                                                  match_neighbor_roll,
    output logic                                                  result_strobe,
    output copad_match_pkg::cluster_vec_t                         match,
    output copad_match_pkg::cluster_vec_t                         match_upper,
    output copad_match_pkg::cluster_vec_t                         match_lower,
    output logic                                                  any_match
);

    // window stage -> pair match
    logic                                                  win_strobe;
    copad_match_pkg::cluster_vec_t                         win_a_vpf;
    copad_geom_pkg::roll_t [copad_geom_pkg::N_CLUSTERS-1:0] win_a_roll;
    copad_geom_pkg::pad_t  [copad_geom_pkg::N_CLUSTERS-1:0] win_min;
    copad_geom_pkg::pad_t  [copad_geom_pkg::N_CLUSTERS-1:0] win_max;
    copad_match_pkg::cluster_vec_t                         win_b_vpf;
    copad_geom_pkg::roll_t [copad_geom_pkg::N_CLUSTERS-1:0] win_b_roll;
    copad_geom_pkg::pad_t  [copad_geom_pkg::N_CLUSTERS-1:0] win_b_pad;
    copad_geom_pkg::cnt_t  [copad_geom_pkg::N_CLUSTERS-1:0] win_b_cnt;
    logic                                                  neighbor_roll;

    // pair hits, [A][B]
    logic [copad_geom_pkg::N_CLUSTERS-1:0][copad_geom_pkg::N_CLUSTERS-1:0] hit_same;
    logic [copad_geom_pkg::N_CLUSTERS-1:0][copad_geom_pkg::N_CLUSTERS-1:0] hit_upper;
    logic [copad_geom_pkg::N_CLUSTERS-1:0][copad_geom_pkg::N_CLUSTERS-1:0] hit_lower;

    copad_window u_window (
        .clock, .rst_n, .bx_strobe,
        .a_vpf, .a_roll, .a_pad, .a_cnt,
        .b_vpf, .b_roll, .b_pad, .b_cnt,
        .match_neighbor_pad, .match_delta_pad, .match_neighbor_roll,
        .win_strobe, .win_a_vpf, .win_a_roll, .win_min, .win_max,
        .win_b_vpf, .win_b_roll, .win_b_pad, .win_b_cnt,
        .neighbor_roll
    );

    copad_pair_match u_pair_match (
        .win_a_vpf, .win_a_roll, .win_min, .win_max,
        .win_b_vpf, .win_b_roll, .win_b_pad, .win_b_cnt,
        .hit_same, .hit_upper, .hit_lower
    );

    copad_result u_result (
        .clock, .rst_n, .win_strobe, .neighbor_roll,
        .hit_same, .hit_upper, .hit_lower,
        .result_strobe, .match, .match_upper, .match_lower, .any_match
    );

    // every crossing comes out exactly PIPE_LATENCY cycles later
    a_latency : assert property (@(posedge clock) disable iff (!rst_n)
        bx_strobe |-> ##(copad_match_pkg::PIPE_LATENCY) result_strobe);

endmodule

// File: source/copad_result.sv
//--------------------
// copad_result
// result stage: ORs the pair hits per A cluster, applies
// the neighbor-roll option, registers the result vectors
//--------------------

`timescale 1ns/100ps

module copad_result (
    input  logic                                 clock,
    input  logic                                 rst_n,
    input  logic                                 win_strobe,
    input  logic                                 neighbor_roll,
    input  logic [copad_geom_pkg::N_CLUSTERS-1:0][copad_geom_pkg::N_CLUSTERS-1:0] hit_same,
    input  logic [copad_geom_pkg::N_CLUSTERS-1:0][copad_geom_pkg::N_CLUSTERS-1:0] hit_upper,
    input  logic [copad_geom_pkg::N_CLUSTERS-1:0][copad_geom_pkg::N_CLUSTERS-1:0] hit_lower,
    output logic                                 result_strobe,
    output copad_match_pkg::cluster_vec_t        match,
    output copad_match_pkg::cluster_vec_t        match_upper,
    output copad_match_pkg::cluster_vec_t        match_lower,
    output logic                                 any_match
);

    copad_match_pkg::cluster_vec_t row_same;
    copad_match_pkg::cluster_vec_t row_upper;
    copad_match_pkg::cluster_vec_t row_lower;
    copad_match_pkg::cluster_vec_t match_next;

    //--------------------
    // row reduction
    //--------------------

    always_comb begin
        for (int a = 0; a < copad_geom_pkg::N_CLUSTERS; a++) begin
            row_same[a]  = |hit_same[a];  // any B cluster
            row_upper[a] = |hit_upper[a];
            row_lower[a] = |hit_lower[a];
        end
    end

    // neighbor rolls count as a full match only when enabled
    assign match_next = neighbor_roll ? (row_same | row_upper | row_lower) : row_same;

    //--------------------
    // output registers
    //--------------------

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            result_strobe <= 1'b0;
            match         <= '0;
            match_upper   <= '0;
            match_lower   <= '0;
            any_match     <= 1'b0;
        end else begin
            result_strobe <= win_strobe;
            if (win_strobe) begin   // hold until the next crossing
                match       <= match_next;
                match_upper <= row_upper;
                match_lower <= row_lower;
                any_match   <= |match_next;
            end
        end
    end

    a_any_match : assert property (@(posedge clock) disable iff (!rst_n)
        result_strobe |-> (any_match == (|match)));

    // a result only comes from a window handed over one cycle earlier
    a_strobe_src : assert property (@(posedge clock) disable iff (!rst_n)
        $rose(result_strobe) |-> $past(win_strobe));

endmodule

// File: source/copad_pair_match.sv
//--------------------
// copad_pair_match
// execute stage: checks every A/B cluster pair for pad
// overlap in the same roll and in both neighbor rolls
//--------------------

`timescale 1ns/100ps

module copad_pair_match (
    input  copad_match_pkg::cluster_vec_t                         win_a_vpf,
    input  copad_geom_pkg::roll_t [copad_geom_pkg::N_CLUSTERS-1:0] win_a_roll,
    input  copad_geom_pkg::pad_t  [copad_geom_pkg::N_CLUSTERS-1:0] win_min,
    input  copad_geom_pkg::pad_t  [copad_geom_pkg::N_CLUSTERS-1:0] win_max,
    input  copad_match_pkg::cluster_vec_t                         win_b_vpf,
    input  copad_geom_pkg::roll_t [copad_geom_pkg::N_CLUSTERS-1:0] win_b_roll,
    input  copad_geom_pkg::pad_t  [copad_geom_pkg::N_CLUSTERS-1:0] win_b_pad,
    input  copad_geom_pkg::cnt_t  [copad_geom_pkg::N_CLUSTERS-1:0] win_b_cnt,
    // [A cluster][B cluster]
    output logic [copad_geom_pkg::N_CLUSTERS-1:0][copad_geom_pkg::N_CLUSTERS-1:0] hit_same,
    output logic [copad_geom_pkg::N_CLUSTERS-1:0][copad_geom_pkg::N_CLUSTERS-1:0] hit_upper,
    output logic [copad_geom_pkg::N_CLUSTERS-1:0][copad_geom_pkg::N_CLUSTERS-1:0] hit_lower
);

    localparam copad_geom_pkg::roll_t LAST_ROLL =
        copad_geom_pkg::roll_t'(copad_geom_pkg::N_ROLLS - 1);

    //--------------------
    // 8 x 8 pair array
    //--------------------

    for (genvar ia = 0; ia < copad_geom_pkg::N_CLUSTERS; ia++) begin : g_a
        for (genvar ib = 0; ib < copad_geom_pkg::N_CLUSTERS; ib++) begin : g_b
            logic [8:0] b_end;       // last pad of the B cluster
            logic       start_in;
            logic       end_in;
            logic       overlap;
            logic       both_valid;
            logic       roll_up;     // B sits one roll lower in number
            logic       roll_down;   // B sits one roll higher in number

            assign b_end = 9'(win_b_pad[ib]) + 9'(win_b_cnt[ib]);

            assign start_in = (win_b_pad[ib] >= win_min[ia]) && (win_b_pad[ib] <= win_max[ia]);
            assign end_in   = (b_end >= 9'(win_min[ia])) && (b_end <= 9'(win_max[ia]));
            assign overlap  = start_in || end_in;

            assign both_valid = win_a_vpf[ia] && win_b_vpf[ib];

            // roll 0 has nothing above it, the last roll nothing below
            assign roll_up = (win_a_roll[ia] != '0)
                && (win_b_roll[ib] == copad_geom_pkg::roll_t'(win_a_roll[ia] - 3'd1));
            assign roll_down = (win_a_roll[ia] != LAST_ROLL)
                && (win_b_roll[ib] == copad_geom_pkg::roll_t'(win_a_roll[ia] + 3'd1));

            assign hit_same[ia][ib]  = both_valid && overlap
                                    && (win_b_roll[ib] == win_a_roll[ia]);
            assign hit_upper[ia][ib] = both_valid && overlap && roll_up;
            assign hit_lower[ia][ib] = both_valid && overlap && roll_down;
        end
    end

endmodule

// File: source/copad_window.sv
//--------------------
// copad_window
// decode stage: builds the pad window of every A cluster
// and registers it together with the B clusters and the
// roll option of the same crossing
//--------------------

`timescale 1ns/100ps

module copad_window (
    input  logic                                                  clock,
    input  logic                                                  rst_n,
    input  logic                                                  bx_strobe,
    input  copad_match_pkg::cluster_vec_t                         a_vpf,
    input  copad_geom_pkg::roll_t [copad_geom_pkg::N_CLUSTERS-1:0] a_roll,
    input  copad_geom_pkg::pad_t  [copad_geom_pkg::N_CLUSTERS-1:0] a_pad,
    input  copad_geom_pkg::cnt_t  [copad_geom_pkg::N_CLUSTERS-1:0] a_cnt,
    input  copad_match_pkg::cluster_vec_t                         b_vpf,
    input  copad_geom_pkg::roll_t [copad_geom_pkg::N_CLUSTERS-1:0] b_roll,
    input  copad_geom_pkg::pad_t  [copad_geom_pkg::N_CLUSTERS-1:0] b_pad,
    input  copad_geom_pkg::cnt_t  [copad_geom_pkg::N_CLUSTERS-1:0] b_cnt,
    input  logic                                                  match_neighbor_pad,
    input  copad_match_pkg::delta_t                               match_delta_pad,
    input  logic                                                  match_neighbor_roll,
    output logic                                                  win_strobe,
    output copad_match_pkg::cluster_vec_t                         win_a_vpf,
    output copad_geom_pkg::roll_t [copad_geom_pkg::N_CLUSTERS-1:0] win_a_roll,
    output copad_geom_pkg::pad_t  [copad_geom_pkg::N_CLUSTERS-1:0] win_min,
    output copad_geom_pkg::pad_t  [copad_geom_pkg::N_CLUSTERS-1:0] win_max,
    output copad_match_pkg::cluster_vec_t                         win_b_vpf,
    output copad_geom_pkg::roll_t [copad_geom_pkg::N_CLUSTERS-1:0] win_b_roll,
    output copad_geom_pkg::pad_t  [copad_geom_pkg::N_CLUSTERS-1:0] win_b_pad,
    output copad_geom_pkg::cnt_t  [copad_geom_pkg::N_CLUSTERS-1:0] win_b_cnt,
    output logic                                                  neighbor_roll
);

    copad_match_pkg::delta_t                              delta_eff;
    logic [copad_geom_pkg::N_CLUSTERS-1:0][8:0]           span_end;  // 9 bits, no wrap past 255
    copad_geom_pkg::pad_t [copad_geom_pkg::N_CLUSTERS-1:0] lo_pad;
    copad_geom_pkg::pad_t [copad_geom_pkg::N_CLUSTERS-1:0] hi_pad;
    logic                                                 win_order_ok;

    //--------------------
    // window edges
    //--------------------

    assign delta_eff = match_neighbor_pad ? match_delta_pad : '0; // exact span when off

    always_comb begin
        for (int i = 0; i < copad_geom_pkg::N_CLUSTERS; i++) begin
            span_end[i] = 9'(a_pad[i]) + 9'(a_cnt[i]) + 9'(delta_eff);
            // low edge stops at pad 0
            lo_pad[i] = (a_pad[i] < 8'(delta_eff)) ? '0 : a_pad[i] - 8'(delta_eff);
            // high edge stops at the last pad of the roll
            hi_pad[i] = (span_end[i] > 9'(copad_geom_pkg::MAX_PAD))
                      ? copad_geom_pkg::pad_t'(copad_geom_pkg::MAX_PAD)
                      : span_end[i][7:0];
        end
    end

    //--------------------
    // crossing registers
    //--------------------

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            win_strobe <= 1'b0;
        end else begin
            win_strobe <= bx_strobe;
        end
    end

    // payload follows the strobe, held between crossings
    always_ff @(posedge clock) begin
        if (bx_strobe) begin
            win_a_vpf     <= a_vpf;
            win_a_roll    <= a_roll;
            win_min       <= lo_pad;
            win_max       <= hi_pad;
            win_b_vpf     <= b_vpf;
            win_b_roll    <= b_roll;
            win_b_pad     <= b_pad;
            win_b_cnt     <= b_cnt;
            neighbor_roll <= match_neighbor_roll; // config rides with its crossing
        end
    end

    always_comb begin
        win_order_ok = 1'b1;
        for (int i = 0; i < copad_geom_pkg::N_CLUSTERS; i++) begin
            if (win_a_vpf[i] && (win_min[i] > win_max[i])) begin
                win_order_ok = 1'b0;
            end
        end
    end

    // clamping never turns a valid window inside out
    a_win_order : assert property (@(posedge clock) disable iff (!rst_n)
        win_strobe |-> win_order_ok);

endmodule

// File: source/copad_match_pkg.sv
//--------------------
// match window delta type
// per-cluster result vector
// pipeline latency
//--------------------

package copad_match_pkg;

    // pad tolerance on each side of the window
    typedef logic [3:0] delta_t;

    // one bit per A cluster, also used for valid flags
    typedef logic [copad_geom_pkg::N_CLUSTERS-1:0] cluster_vec_t;

    // cycles from bx_strobe to result_strobe
    // window stage + result stage
    localparam int PIPE_LATENCY = 2;

endpackage

// File: source/copad_geom_pkg.sv
//--------------------
// chamber geometry constants
// cluster field types: roll, start pad, extra pad count
//--------------------

package copad_geom_pkg;

    //--------------------
    // chamber geometry
    //--------------------

    // clusters delivered per chamber in one bunch crossing
    localparam int N_CLUSTERS = 8;

    localparam int N_ROLLS = 8; // eta partitions per chamber

    // every roll has pads 0 to MAX_PAD
    localparam int MAX_PAD = 191;

    //--------------------
    // cluster fields
    //--------------------

    // roll 0 is the top of the chamber
    typedef logic [2:0] roll_t;

    typedef logic [7:0] pad_t; // first pad hit by the cluster

    // pads hit beyond the first one, 0 to 7
    typedef logic [2:0] cnt_t;

endpackage
